//--- hw/lsq_defs.svh
`ifndef LSQ_DEFS_SVH
`define LSQ_DEFS_SVH

// Store slots in the queue
`define LSQ_DEPTH 8

// Slot index bits, without the wrap bit
`define LSQ_PTR_BITS $clog2(`LSQ_DEPTH)

// Byte address width
`define LSQ_ADDR_WIDTH 32

// Data word width
`define LSQ_DATA_WIDTH 64

// Byte offset inside a doubleword, ignored in address compares
`define LSQ_OFFSET_BITS 3

// Doubleword address width
`define LSQ_DWORD_WIDTH (`LSQ_ADDR_WIDTH - `LSQ_OFFSET_BITS)

`endif

//--- hw/lsq_pkg.sv
`include "lsq_defs.svh"

package lsq_pkg;

  // Slot index with the wrap bit on top
  typedef logic [`LSQ_PTR_BITS:0] sq_idx_t;

  // Address of a whole doubleword
  typedef logic [`LSQ_DWORD_WIDTH-1:0] dword_addr_t;

  typedef logic [`LSQ_DATA_WIDTH-1:0] lsq_data_t;

  // One store slot
  typedef struct packed {
    logic        executed;
    dword_addr_t addr;
    lsq_data_t   data;
  } store_entry_t;

endpackage

//--- hw/lsq_ring_pointers.sv
`timescale 1ns/1ps
`include "lsq_defs.svh"

module lsq_ring_pointers (
  input  logic             clock,
  input  logic             reset,
  input  logic             alloc,
  input  logic             drain,
  input  logic             commit,
  output lsq_pkg::sq_idx_t head,
  output lsq_pkg::sq_idx_t tail,
  output logic             full,
  output logic             has_pending
);

  localparam int PTR_BITS = `LSQ_PTR_BITS;

  // Committed stores not yet written to memory
  logic [PTR_BITS:0] pending;

  // Same slot, opposite lap
  assign full        = (head ^ tail) == {1'b1, {PTR_BITS{1'b0}}};
  assign has_pending = pending != '0;

  always_ff @(posedge clock) begin
    if (reset) begin
      head    <= '0;
      tail    <= '0;
      pending <= '0;
    end else begin
      if (alloc) begin
        tail <= tail + 1'b1;
      end
      if (drain) begin
        head <= head + 1'b1;
      end
      case ({commit, drain})
        2'b10: begin
          pending <= pending + 1'b1;
        end
        2'b01: begin
          pending <= pending - 1'b1;
        end
        default: begin
          pending <= pending;
        end
      endcase
    end
  end

endmodule

//--- hw/store_queue.sv
`timescale 1ns/1ps
`include "lsq_defs.svh"

module store_queue (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic                                   store_alloc_valid,
  output logic                                   store_alloc_ready,
  output lsq_pkg::sq_idx_t                       store_alloc_idx,
  input  logic                                   store_exec_valid,
  input  lsq_pkg::sq_idx_t                       store_exec_idx,
  input  lsq_pkg::dword_addr_t                   store_exec_addr,
  input  lsq_pkg::lsq_data_t                     store_exec_data,
  input  logic                                   store_commit,
  output logic                                   mem_wr_valid,
  input  logic                                   mem_wr_ready,
  output lsq_pkg::dword_addr_t                   mem_wr_addr,
  output lsq_pkg::lsq_data_t                     mem_wr_data,
  output lsq_pkg::store_entry_t [`LSQ_DEPTH-1:0] entries,
  output lsq_pkg::sq_idx_t                       head
);

  import lsq_pkg::*;

  localparam int PTR_BITS = `LSQ_PTR_BITS;

  sq_idx_t               tail;
  logic                  full;
  logic                  has_pending;
  logic                  alloc;
  logic                  drain;
  logic [PTR_BITS-1:0]   tail_slot;
  logic [PTR_BITS-1:0]   exec_slot;
  logic [PTR_BITS-1:0]   head_slot;
  logic [`LSQ_DEPTH-1:0] executed;
  dword_addr_t           addr_mem [`LSQ_DEPTH];
  lsq_data_t             data_mem [`LSQ_DEPTH];

  assign tail_slot = tail[PTR_BITS-1:0];
  assign exec_slot = store_exec_idx[PTR_BITS-1:0];
  assign head_slot = head[PTR_BITS-1:0];

  assign store_alloc_ready = !full;
  assign store_alloc_idx   = tail;
  assign alloc             = store_alloc_valid && store_alloc_ready;

  // Head goes out only once it is both committed and executed
  assign mem_wr_valid = has_pending && executed[head_slot];
  assign mem_wr_addr  = addr_mem[head_slot];
  assign mem_wr_data  = data_mem[head_slot];
  assign drain        = mem_wr_valid && mem_wr_ready;

  lsq_ring_pointers u_pointers (
    .clock       (clock),
    .reset       (reset),
    .alloc       (alloc),
    .drain       (drain),
    .commit      (store_commit),
    .head        (head),
    .tail        (tail),
    .full        (full),
    .has_pending (has_pending)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      executed <= '0;
    end else begin
      if (alloc) begin
        executed[tail_slot] <= 1'b0;
      end
      if (store_exec_valid) begin
        executed[exec_slot] <= 1'b1;
      end
    end
  end

  // Address and data written by the function unit
  always_ff @(posedge clock) begin
    if (store_exec_valid) begin
      addr_mem[exec_slot] <= store_exec_addr;
      data_mem[exec_slot] <= store_exec_data;
    end
  end

  always_comb begin
    for (int i = 0; i < `LSQ_DEPTH; i++) begin
      entries[i].executed = executed[i];
      entries[i].addr     = addr_mem[i];
      entries[i].data     = data_mem[i];
    end
  end

endmodule

//--- hw/store_forward.sv
`timescale 1ns/1ps
`include "lsq_defs.svh"

module store_forward (
  input  lsq_pkg::store_entry_t [`LSQ_DEPTH-1:0] entries,
  input  lsq_pkg::sq_idx_t                       head,
  input  lsq_pkg::sq_idx_t                       load_sq_idx,
  input  lsq_pkg::dword_addr_t                   lookup_addr,
  output logic                                   hit,
  output lsq_pkg::lsq_data_t                     hit_data
);

  import lsq_pkg::*;

  localparam int PTR_BITS = `LSQ_PTR_BITS;

  // Number of stores older than the load still in the queue
  sq_idx_t span;

  assign span = load_sq_idx - head;

  // Youngest first, so the first match wins
  always_comb begin
    sq_idx_t             slot;
    logic [PTR_BITS-1:0] s;

    hit      = 1'b0;
    hit_data = '0;
    slot     = '0;
    s        = '0;
    for (int j = 0; j < `LSQ_DEPTH; j++) begin
      slot = load_sq_idx - sq_idx_t'(j + 1);
      s    = slot[PTR_BITS-1:0];
      if (!hit && (j < int'(span)) && entries[s].executed &&
          entries[s].addr == lookup_addr) begin
        hit      = 1'b1;
        hit_data = entries[s].data;
      end
    end
  end

endmodule

//--- hw/load_unit.sv
`timescale 1ns/1ps
`include "lsq_defs.svh"

module load_unit (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        load_valid,
  output logic                        load_ready,
  input  logic [`LSQ_ADDR_WIDTH-1:0]  load_addr,
  input  lsq_pkg::sq_idx_t            load_sq_idx,
  output lsq_pkg::dword_addr_t        lookup_addr,
  output lsq_pkg::sq_idx_t            lookup_sq_idx,
  input  logic                        fwd_hit,
  input  lsq_pkg::lsq_data_t          fwd_data,
  output logic                        mem_rd_valid,
  input  logic                        mem_rd_ready,
  output lsq_pkg::dword_addr_t        mem_rd_addr,
  input  logic                        mem_rd_resp_valid,
  input  lsq_pkg::lsq_data_t          mem_rd_resp_data,
  output logic                        load_resp_valid,
  output lsq_pkg::lsq_data_t          load_resp_data,
  output logic                        load_resp_forwarded
);

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT,
    RESPOND
  } state_t;

  state_t state;
  logic   accept;

  // Incoming load drives the forward search directly
  assign lookup_addr   = load_addr[`LSQ_ADDR_WIDTH-1:`LSQ_OFFSET_BITS];
  assign lookup_sq_idx = load_sq_idx;

  assign load_ready      = state == IDLE;
  assign accept          = load_valid && load_ready;
  assign mem_rd_valid    = state == REQUEST;
  assign load_resp_valid = state == RESPOND;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state <= fwd_hit ? RESPOND : REQUEST;
          end
        end
        REQUEST: begin
          if (mem_rd_ready) begin
            state <= WAIT;
          end
        end
        WAIT: begin
          if (mem_rd_resp_valid) begin
            state <= RESPOND;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Response payload and read address
  always_ff @(posedge clock) begin
    if (accept) begin
      mem_rd_addr         <= lookup_addr;
      load_resp_data      <= fwd_data;
      load_resp_forwarded <= fwd_hit;
    end else if (state == WAIT && mem_rd_resp_valid) begin
      load_resp_data      <= mem_rd_resp_data;
      load_resp_forwarded <= 1'b0;
    end
  end

endmodule

//--- hw/lsq.sv
`timescale 1ns/1ps
`include "lsq_defs.svh"

module lsq (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       store_alloc_valid,
  output logic                       store_alloc_ready,
  output lsq_pkg::sq_idx_t           store_alloc_idx,
  input  logic                       store_exec_valid,
  input  lsq_pkg::sq_idx_t           store_exec_idx,
  input  lsq_pkg::dword_addr_t       store_exec_addr,
  input  lsq_pkg::lsq_data_t         store_exec_data,
  input  logic                       store_commit,
  output logic                       mem_wr_valid,
  input  logic                       mem_wr_ready,
  output lsq_pkg::dword_addr_t       mem_wr_addr,
  output lsq_pkg::lsq_data_t         mem_wr_data,
  input  logic                       load_valid,
  output logic                       load_ready,
  input  logic [`LSQ_ADDR_WIDTH-1:0] load_addr,
  input  lsq_pkg::sq_idx_t           load_sq_idx,
  output logic                       mem_rd_valid,
  input  logic                       mem_rd_ready,
  output lsq_pkg::dword_addr_t       mem_rd_addr,
  input  logic                       mem_rd_resp_valid,
  input  lsq_pkg::lsq_data_t         mem_rd_resp_data,
  output logic                       load_resp_valid,
  output lsq_pkg::lsq_data_t         load_resp_data,
  output logic                       load_resp_forwarded
);

  import lsq_pkg::*;

  store_entry_t [`LSQ_DEPTH-1:0] entries;
  sq_idx_t                       head;
  sq_idx_t                       lookup_sq_idx;
  dword_addr_t                   lookup_addr;
  logic                          fwd_hit;
  lsq_data_t                     fwd_data;

  store_queue u_store_queue (
    .clock             (clock),
    .reset             (reset),
    .store_alloc_valid (store_alloc_valid),
    .store_alloc_ready (store_alloc_ready),
    .store_alloc_idx   (store_alloc_idx),
    .store_exec_valid  (store_exec_valid),
    .store_exec_idx    (store_exec_idx),
    .store_exec_addr   (store_exec_addr),
    .store_exec_data   (store_exec_data),
    .store_commit      (store_commit),
    .mem_wr_valid      (mem_wr_valid),
    .mem_wr_ready      (mem_wr_ready),
    .mem_wr_addr       (mem_wr_addr),
    .mem_wr_data       (mem_wr_data),
    .entries           (entries),
    .head              (head)
  );

  store_forward u_store_forward (
    .entries     (entries),
    .head        (head),
    .load_sq_idx (lookup_sq_idx),
    .lookup_addr (lookup_addr),
    .hit         (fwd_hit),
    .hit_data    (fwd_data)
  );

  load_unit u_load_unit (
    .clock               (clock),
    .reset               (reset),
    .load_valid          (load_valid),
    .load_ready          (load_ready),
    .load_addr           (load_addr),
    .load_sq_idx         (load_sq_idx),
    .lookup_addr         (lookup_addr),
    .lookup_sq_idx       (lookup_sq_idx),
    .fwd_hit             (fwd_hit),
    .fwd_data            (fwd_data),
    .mem_rd_valid        (mem_rd_valid),
    .mem_rd_ready        (mem_rd_ready),
    .mem_rd_addr         (mem_rd_addr),
    .mem_rd_resp_valid   (mem_rd_resp_valid),
    .mem_rd_resp_data    (mem_rd_resp_data),
    .load_resp_valid     (load_resp_valid),
    .load_resp_data      (load_resp_data),
    .load_resp_forwarded (load_resp_forwarded)
  );

endmodule

//--- test/lsq_tb_cases.svh
// Columns are op, name, byte address, data, tag, expected data and expected forwarded flag
add_case(OP_READY,  "ready_after_reset", 0, 64'd1, 0, 0, 0);
add_case(OP_ALLOC,  "alloc_0",  0, 0, 0, 0, 0);
add_case(OP_ALLOC,  "alloc_1",  0, 0, 1, 0, 0);
add_case(OP_ALLOC,  "alloc_2",  0, 0, 2, 0, 0);
add_case(OP_ALLOC,  "alloc_3",  0, 0, 3, 0, 0);
add_case(OP_ALLOC,  "alloc_4",  0, 0, 4, 0, 0);
add_case(OP_ALLOC,  "alloc_5",  0, 0, 5, 0, 0);
add_case(OP_ALLOC,  "alloc_6",  0, 0, 6, 0, 0);
add_case(OP_ALLOC,  "alloc_7",  0, 0, 7, 0, 0);
add_case(OP_READY,  "full_after_8", 0, 64'd0, 0, 0, 0);
// Younger of two stores to one doubleword wins
add_case(OP_EXEC,   "exec_0", 32'h1000, 64'h1111_0000_0000_0011, 0, 0, 0);
add_case(OP_EXEC,   "exec_1", 32'h1004, 64'h2222_0000_0000_0022, 1, 0, 0);
add_case(OP_LOAD,   "fwd_younger", 32'h1006, 0, 2, 64'h2222_0000_0000_0022, 1);
add_case(OP_LOAD,   "fwd_offset",  32'h1003, 0, 1, 64'h1111_0000_0000_0011, 1);
// Tag 2 is not executed and tag 3 is younger than the load
add_case(OP_EXEC,   "exec_3", 32'h2000, 64'h3333_0000_0000_0033, 3, 0, 0);
add_case(OP_LOAD,   "no_fwd_unexec", 32'h2000, 0, 3, fill_pattern(dword_of(32'h2000)), 0);
add_case(OP_LOAD,   "miss_all", 32'h3005, 0, 8, fill_pattern(dword_of(32'h3005)), 0);
add_case(OP_COMMIT, "commit_0", 0, 0, 0, 0, 0);
add_case(OP_DRAIN,  "drain_0",  0, 0, 0, 0, 0);
add_case(OP_READY,  "ready_after_drain", 0, 64'd1, 0, 0, 0);
add_case(OP_ALLOC,  "alloc_8",  0, 0, 8, 0, 0);
add_case(OP_EXEC,   "exec_2", 32'h2000, 64'h4444_0000_0000_0044, 2, 0, 0);
add_case(OP_EXEC,   "exec_4", 32'h4000, 64'h5555_0000_0000_0055, 4, 0, 0);
add_case(OP_EXEC,   "exec_5", 32'h4008, 64'h6666_0000_0000_0066, 5, 0, 0);
add_case(OP_EXEC,   "exec_6", 32'h4010, 64'h7777_0000_0000_0077, 6, 0, 0);
add_case(OP_EXEC,   "exec_7", 32'h4018, 64'h8888_0000_0000_0088, 7, 0, 0);
add_case(OP_COMMIT, "commit_1", 0, 0, 1, 0, 0);
add_case(OP_COMMIT, "commit_2", 0, 0, 2, 0, 0);
add_case(OP_COMMIT, "commit_3", 0, 0, 3, 0, 0);
add_case(OP_DRAIN,  "drain_3",  0, 0, 0, 0, 0);
// Drained stores now come from memory
add_case(OP_LOAD,   "drained_2000", 32'h2000, 0, 9, 64'h3333_0000_0000_0033, 0);
add_case(OP_LOAD,   "drained_1000", 32'h1007, 0, 9, 64'h2222_0000_0000_0022, 0);
add_case(OP_LOAD,   "fwd_4010",     32'h4012, 0, 9, 64'h7777_0000_0000_0077, 1);
add_case(OP_COMMIT, "commit_4", 0, 0, 4, 0, 0);
add_case(OP_COMMIT, "commit_5", 0, 0, 5, 0, 0);
add_case(OP_COMMIT, "commit_6", 0, 0, 6, 0, 0);
add_case(OP_COMMIT, "commit_7", 0, 0, 7, 0, 0);
add_case(OP_DRAIN,  "drain_7",  0, 0, 0, 0, 0);
add_case(OP_LOAD,   "drained_4018", 32'h4018, 0, 9, 64'h8888_0000_0000_0088, 0);

//--- test/lsq_tb.sv
`timescale 1ns/1ps
`include "lsq_defs.svh"

module lsq_tb;

  localparam time CLK_PERIOD  = 100ns;
  localparam time DRIVE_DELAY = 10ns;
  localparam int  RESET_CYCLES = 16;
  localparam int  RD_LATENCY   = 3;

  typedef enum int {OP_ALLOC, OP_EXEC, OP_COMMIT, OP_LOAD, OP_DRAIN, OP_READY} op_t;

  typedef struct {
    op_t         op;
    string       name;
    logic [31:0] addr;
    logic [63:0] data;
    int          tag;
    logic [63:0] exp_data;
    logic        exp_fwd;
  } case_t;

  logic clock;
  logic reset;
  logic store_alloc_valid, store_alloc_ready;
  logic [3:0] store_alloc_idx;
  logic store_exec_valid;
  logic [3:0] store_exec_idx;
  logic [28:0] store_exec_addr;
  logic [63:0] store_exec_data;
  logic store_commit;
  logic mem_wr_valid;
  logic mem_wr_ready = 1'b0;
  logic [28:0] mem_wr_addr;
  logic [63:0] mem_wr_data;
  logic load_valid, load_ready;
  logic [31:0] load_addr;
  logic [3:0] load_sq_idx;
  logic mem_rd_valid;
  logic mem_rd_ready = 1'b0;
  logic [28:0] mem_rd_addr;
  logic mem_rd_resp_valid = 1'b0;
  logic [63:0] mem_rd_resp_data = '0;
  logic load_resp_valid;
  logic [63:0] load_resp_data;
  logic load_resp_forwarded;

  case_t       cases[$];
  logic [63:0] memory[logic [28:0]];
  logic [28:0] slot_addr[8];
  logic [63:0] slot_data[8];
  logic [28:0] wr_addr_q[$];
  logic [63:0] wr_data_q[$];
  bit          rd_busy;
  int          rd_wait;
  logic [28:0] rd_addr;

  lsq uut (.*);

  function automatic logic [28:0] dword_of(logic [31:0] a);
    return a[31:3];
  endfunction

  // Value of a doubleword never written
  function automatic logic [63:0] fill_pattern(logic [28:0] a);
    return {6'h2d, a, ~a};
  endfunction

  function automatic logic [63:0] mem_read(logic [28:0] a);
    return memory.exists(a) ? memory[a] : fill_pattern(a);
  endfunction

  task automatic add_case(op_t op, string name, logic [31:0] addr, logic [63:0] data,
                          int tag, logic [63:0] exp_data, logic exp_fwd);
    cases.push_back('{op, name, addr, data, tag, exp_data, exp_fwd});
  endtask

  task automatic check(string name, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #DRIVE_DELAY;
  endtask

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // Memory write port checked against commit order
  always @(posedge clock) begin
    if (!reset && mem_wr_valid && mem_wr_ready) begin
      if (wr_addr_q.size() == 0) begin
        $display("Memory write seen with no committed store outstanding");
        $display("TEST FAILED");
        $fatal(1, "unexpected write");
      end else begin
        check("mem_wr_addr", 64'(wr_addr_q.pop_front()), 64'(mem_wr_addr));
        check("mem_wr_data", wr_data_q.pop_front(), mem_wr_data);
        memory[mem_wr_addr] = mem_wr_data;
      end
    end
    #DRIVE_DELAY;
    mem_wr_ready = ($urandom % 3) != 0;
  end

  // Memory read port answering RD_LATENCY cycles after acceptance
  always @(posedge clock) begin
    if (!reset && mem_rd_valid && mem_rd_ready) begin
      rd_busy = 1'b1;
      rd_wait = RD_LATENCY;
      rd_addr = mem_rd_addr;
    end
    #DRIVE_DELAY;
    mem_rd_resp_valid = 1'b0;
    if (rd_busy) begin
      rd_wait--;
      if (rd_wait == 0) begin
        mem_rd_resp_valid = 1'b1;
        mem_rd_resp_data  = mem_read(rd_addr);
        rd_busy           = 1'b0;
      end
    end
    mem_rd_ready = !rd_busy && (($urandom % 3) != 0);
  end

  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + 4));
    #(CLK_PERIOD * cases.size() * 50);
    $display("Watchdog expired before all cases finished");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    void'($urandom(32'he16a_9bf8));
    reset = 1'b1;
    store_alloc_valid = 1'b0;
    store_exec_valid = 1'b0;
    store_exec_idx = '0;
    store_exec_addr = '0;
    store_exec_data = '0;
    store_commit = 1'b0;
    load_valid = 1'b0;
    load_addr = '0;
    load_sq_idx = '0;
    `include "lsq_tb_cases.svh"
    repeat (RESET_CYCLES) @(posedge clock);
    #DRIVE_DELAY;
    reset = 1'b0;
    check("load_ready_after_reset", 1, 64'(load_ready));
    check("mem_wr_valid_after_reset", 0, 64'(mem_wr_valid));
    check("mem_rd_valid_after_reset", 0, 64'(mem_rd_valid));
    check("load_resp_valid_after_reset", 0, 64'(load_resp_valid));
    foreach (cases[i]) begin
      case (cases[i].op)
        OP_READY: check(cases[i].name, cases[i].data, 64'(store_alloc_ready));
        OP_ALLOC: begin
          check({cases[i].name, "_ready"}, 1, 64'(store_alloc_ready));
          check({cases[i].name, "_idx"}, 64'(cases[i].tag), 64'(store_alloc_idx));
          store_alloc_valid = 1'b1;
          next_cycle();
          store_alloc_valid = 1'b0;
        end
        OP_EXEC: begin
          store_exec_valid = 1'b1;
          store_exec_idx   = 4'(cases[i].tag);
          store_exec_addr  = dword_of(cases[i].addr);
          store_exec_data  = cases[i].data;
          slot_addr[3'(cases[i].tag)] = dword_of(cases[i].addr);
          slot_data[3'(cases[i].tag)] = cases[i].data;
          next_cycle();
          store_exec_valid = 1'b0;
        end
        OP_COMMIT: begin
          wr_addr_q.push_back(slot_addr[3'(cases[i].tag)]);
          wr_data_q.push_back(slot_data[3'(cases[i].tag)]);
          store_commit = 1'b1;
          next_cycle();
          store_commit = 1'b0;
        end
        OP_DRAIN: begin
          while (wr_addr_q.size() != 0) begin
            next_cycle();
          end
        end
        OP_LOAD: begin
          check({cases[i].name, "_load_ready"}, 1, 64'(load_ready));
          load_valid  = 1'b1;
          load_addr   = cases[i].addr;
          load_sq_idx = 4'(cases[i].tag);
          next_cycle();
          load_valid = 1'b0;
          if (cases[i].exp_fwd) begin
            check({cases[i].name, "_resp_valid"}, 1, 64'(load_resp_valid));
          end else begin
            check({cases[i].name, "_rd_valid"}, 1, 64'(mem_rd_valid));
            while (!load_resp_valid) begin
              check({cases[i].name, "_busy"}, 0, 64'(load_ready));
              next_cycle();
            end
          end
          check({cases[i].name, "_data"}, cases[i].exp_data, load_resp_data);
          check({cases[i].name, "_fwd"}, 64'(cases[i].exp_fwd), 64'(load_resp_forwarded));
          next_cycle();
        end
        default: ;
      endcase
    end
    $display("TEST OK");
    $finish;
  end

endmodule

//--- lsq.f
+incdir+hw
hw/lsq_pkg.sv
hw/lsq_ring_pointers.sv
hw/store_queue.sv
hw/store_forward.sv
hw/load_unit.sv
hw/lsq.sv
test/lsq_tb.sv
+incdir+test

//--- Makefile
# Verilator build and run of the LSQ testbench

VERILATOR ?= verilator
TOP       ?= lsq_tb
FILELIST  ?= lsq.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for failure"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard hw/*) $(wildcard test/*)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
